// ==== audio_codec_chk.sv ====
// handshake assertions for the audio codec top level
`timescale 1ns/1ps
`default_nettype none

module audio_codec_chk
(
    input logic clk,
    input logic rst,
    input logic src_sel,
    input logic play_enable,
    input logic play_ready,
    input logic play_ack,
    input logic cap_enable,
    input logic cap_ready,
    input logic cap_write,
    input logic aud_lrclk
);

    // ack only on a real fifo pop at a frame start
    ack_rule: assert property (@(posedge clk) disable iff (rst)
        play_ack |-> (play_ready && play_enable && !src_sel && $fell(aud_lrclk)))
        else $error("play_ack outside the fifo handshake");

    ack_pulse: assert property (@(posedge clk) disable iff (rst) play_ack |=> !play_ack)
        else $error("play_ack high for two cycles");

    write_pulse: assert property (@(posedge clk) disable iff (rst) cap_write |=> !cap_write)
        else $error("cap_write high for two cycles");

    write_rule: assert property (@(posedge clk) disable iff (rst)
        cap_write |-> (cap_ready && cap_enable))
        else $error("cap_write without room or enable");

endmodule

bind audio_codec_top audio_codec_chk chk_inst (.*);

`default_nettype wire

// ==== audio_codec_tb.sv ====
// audio codec testbench for the table driven i2s loopback and key debounce
`timescale 1ns/1ps
`default_nettype none

module audio_codec_tb;

    localparam int BCLK_DIV         = 2;
    localparam int DEBOUNCE_TIMEOUT = 16;
    localparam int TIMEOUT_WIDTH    = 8;
    localparam int NUM_ROWS         = 7;
    localparam int FRAME_WAIT       = 320;  // above the 256 clk frame
    localparam int KEY_WAIT         = DEBOUNCE_TIMEOUT + 8;

    // what the serializer should send for a row
    typedef enum
    {
        EXP_FIFO,   // fifo pair with an ack
        EXP_SYNTH,  // synthesizer pair
        EXP_ZERO    // silence
    } mode_e;

    typedef struct
    {
        logic       src;       // 1 = synthesizer
        logic       pen;
        logic       pready;
        logic       cen;
        logic       cready;
        logic [3:0] key_pat;   // pressed keys
        int         key_hold;  // 0 = no key action
        int         frames;
        mode_e      mode;
    } row_t;

    logic clk;
    logic rst;
    logic [3:0] key;
    logic [3:0] key_state;
    logic src_sel, play_enable, play_ready, play_ack;
    logic cap_enable, cap_ready, cap_write;
    logic [31:0] play_left, play_right, synth_left, synth_right, cap_left, cap_right;
    logic aud_bclk, aud_lrclk;
    wire  dac_loop;  // dac looped to adc

    row_t        rows [NUM_ROWS];
    logic [63:0] expect_q [$];
    logic [31:0] lfsr;
    logic        tracking;
    int          errors;

    tb_clock #(.PERIOD(4.0)) clk_gen (.clk(clk));

    audio_codec_top
    #(
        .BCLK_DIV         (BCLK_DIV),
        .DEBOUNCE_TIMEOUT (DEBOUNCE_TIMEOUT),
        .TIMEOUT_WIDTH    (TIMEOUT_WIDTH)
    ) uut
    (
        .clk(clk), .rst(rst), .key(key), .key_state(key_state),
        .src_sel(src_sel), .play_enable(play_enable),
        .play_left(play_left), .play_right(play_right),
        .play_ready(play_ready), .play_ack(play_ack),
        .synth_left(synth_left), .synth_right(synth_right),
        .cap_enable(cap_enable), .cap_ready(cap_ready),
        .cap_left(cap_left), .cap_right(cap_right), .cap_write(cap_write),
        .aud_bclk(aud_bclk), .aud_lrclk(aud_lrclk),
        .aud_dacdat(dac_loop), .aud_adcdat(dac_loop)
    );

    // ====================
    // helpers
    // ====================

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    // returns just after the clk edge where lrclk drops
    task automatic wait_frame_start();
        logic last_lr;
        logic found;
        last_lr = aud_lrclk;
        found   = 1'b0;
        for (int i = 0; i < FRAME_WAIT && !found; i++)
        begin
            @(posedge clk);
            #1;
            found   = last_lr && !aud_lrclk;
            last_lr = aud_lrclk;
            if (cap_write || (play_ack && !found))
                stop_run("handshake pulse away from a frame start");
        end
        if (!found)
            stop_run("timeout waiting for a frame start on aud_lrclk");
    endtask

    // capture of the frame before the one that just started
    task automatic capture_window(input logic expect_write);
        logic        got;
        logic [63:0] exp;
        got = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            @(posedge clk);
            #1;
            // bclk fell with the frame start, period 2 * BCLK_DIV clks
            check_value("aud_bclk", aud_bclk, ((i + 1) % (2 * BCLK_DIV)) >= BCLK_DIV);
            if (cap_write && tracking)
            begin
                if (got || !expect_write)
                    stop_run("cap_write while capture should be blocked");
                got = 1'b1;
                exp = expect_q.pop_front();
                check_value("cap_left", cap_left, exp[63:32]);
                check_value("cap_right", cap_right, exp[31:0]);
            end
        end
        if (tracking && expect_write && !got)
            stop_run("timeout waiting for cap_write");
        if (tracking && !got)
            void'(expect_q.pop_front());  // frame dropped
    endtask

    task automatic key_test(input logic [3:0] pat, input int hold);
        logic done;
        key  = ~pat;  // pins are active low
        done = 1'b0;
        repeat (hold)
        begin
            @(posedge clk);
            #1;
            if (hold < DEBOUNCE_TIMEOUT)
                check_value("key_state", key_state, 0);
        end
        key = '1;
        if (hold < DEBOUNCE_TIMEOUT)
        begin
            repeat (KEY_WAIT)
            begin
                @(posedge clk);
                #1;
                check_value("key_state", key_state, 0);
            end
        end
        else
        begin
            check_value("key_state", key_state, pat);
            for (int i = 0; i < KEY_WAIT && !done; i++)
            begin
                @(posedge clk);
                #1;
                done = (key_state == 4'b0);
            end
            if (!done)
                stop_run("timeout waiting for key release");
        end
    endtask

    // ====================
    // stimulus and checks
    // ====================
    initial
    begin
        logic        exp_ack;
        logic [63:0] exp_pair;
        rst         = 1'b1;
        key         = '1;
        src_sel     = 0;
        play_enable = 0;
        play_ready  = 0;
        cap_enable  = 0;
        cap_ready   = 0;
        play_left   = '0;
        play_right  = '0;
        synth_left  = '0;
        synth_right = '0;
        lfsr     = 32'hd64f1e61;
        tracking = 1'b0;
        errors   = 0;

        //        src   pen   prdy  cen   crdy  keys     hold frames mode
        rows[0] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 4'b0001, 30, 4, EXP_FIFO};   // fifo loopback
        rows[1] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 4'b0010, 6,  3, EXP_SYNTH};  // synth
        rows[2] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 4'b0000, 0,  2, EXP_ZERO};   // underflow
        rows[3] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 4'b0000, 0,  2, EXP_ZERO};   // playback off
        rows[4] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 4'b0100, 30, 3, EXP_FIFO};   // capture full
        rows[5] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 4'b0000, 0,  3, EXP_FIFO};   // capture off
        rows[6] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 4'b1000, 30, 4, EXP_FIFO};   // resume

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("play_ack", play_ack, 0);
        check_value("cap_write", cap_write, 0);
        check_value("aud_bclk", aud_bclk, 0);
        check_value("aud_dacdat", dac_loop, 0);
        check_value("aud_lrclk", aud_lrclk, 1);
        check_value("key_state", key_state, 0);
        play_left  = next_bits(32);
        play_right = next_bits(32);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            src_sel     = rows[r].src;
            play_enable = rows[r].pen;
            play_ready  = rows[r].pready;
            cap_enable  = rows[r].cen;
            cap_ready   = rows[r].cready;
            synth_left  = next_bits(32);
            synth_right = next_bits(32);
            for (int f = 0; f < rows[r].frames; f++)
            begin
                wait_frame_start();
                exp_ack = (rows[r].mode == EXP_FIFO);
                check_value("play_ack", play_ack, exp_ack);
                case (rows[r].mode)
                    EXP_FIFO:  exp_pair = {play_left, play_right};
                    EXP_SYNTH: exp_pair = {synth_left, synth_right};
                    default:   exp_pair = '0;
                endcase
                expect_q.push_back(exp_pair);
                capture_window(cap_enable && cap_ready);
                tracking = 1'b1;
                if (exp_ack)
                begin
                    play_left  = next_bits(32);  // fifo pops the next pair
                    play_right = next_bits(32);
                end
                if (f == 0 && rows[r].key_hold > 0)
                    key_test(rows[r].key_pat, rows[r].key_hold);
            end
        end

        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== audio_codec_top.sv ====
// audio codec top level, i2s playback and capture path with key debounce
`timescale 1ns/1ps
`default_nettype none

module audio_codec_top
#(
    parameter int BCLK_DIV         = 8,
    parameter int DEBOUNCE_TIMEOUT = 50000,
    parameter int TIMEOUT_WIDTH    = 16
)
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [audio_pkg::NUM_KEYS-1:0] key,
    output logic [audio_pkg::NUM_KEYS-1:0] key_state,
    input  logic                           src_sel,      // 1 = synthesizer
    input  logic                           play_enable,
    input  audio_pkg::sample_t             play_left,
    input  audio_pkg::sample_t             play_right,
    input  logic                           play_ready,
    output logic                           play_ack,
    input  audio_pkg::sample_t             synth_left,
    input  audio_pkg::sample_t             synth_right,
    input  logic                           cap_enable,
    input  logic                           cap_ready,
    output audio_pkg::sample_t             cap_left,
    output audio_pkg::sample_t             cap_right,
    output logic                           cap_write,
    output logic                           aud_bclk,
    output logic                           aud_lrclk,
    output logic                           aud_dacdat,
    input  logic                           aud_adcdat
);

    i2s_bus_if i2s_bus ();

    audio_pkg::audio_src_e play_src;

    assign play_src  = audio_pkg::audio_src_e'(src_sel);
    assign aud_bclk  = i2s_bus.bclk;
    assign aud_lrclk = i2s_bus.lrclk;  // shared by dac and adc

    // ====================
    // i2s path
    // ====================
    i2s_clock_gen #(.BCLK_DIV(BCLK_DIV)) i2s_clock_gen_inst
    (
        .clk         (clk),
        .rst         (rst),
        .bus         (i2s_bus)
    );

    i2s_shift_out i2s_shift_out_inst
    (
        .clk         (clk),
        .rst         (rst),
        .bus         (i2s_bus),
        .enable      (play_enable),
        .src_sel     (play_src),
        .fifo_left   (play_left),
        .fifo_right  (play_right),
        .fifo_ready  (play_ready),
        .fifo_ack    (play_ack),
        .synth_left  (synth_left),
        .synth_right (synth_right),
        .data_out    (aud_dacdat)
    );

    i2s_shift_in i2s_shift_in_inst
    (
        .clk         (clk),
        .rst         (rst),
        .bus         (i2s_bus),
        .enable      (cap_enable),
        .fifo_ready  (cap_ready),
        .data_in     (aud_adcdat),
        .fifo_left   (cap_left),
        .fifo_right  (cap_right),
        .fifo_write  (cap_write)
    );

    // buttons, beside the audio path
    key_debounce
    #(
        .DEBOUNCE_TIMEOUT (DEBOUNCE_TIMEOUT),
        .TIMEOUT_WIDTH    (TIMEOUT_WIDTH)
    ) key_debounce_inst
    (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .key_state   (key_state)
    );

endmodule

`default_nettype wire

// ==== audio_pkg.sv ====
// audio path shared definitions: sample widths, sample type and playback source select
`default_nettype none

package audio_pkg;

    // ====================
    // sample format
    // ====================

    // bits per channel sample
    parameter int SAMPLE_BITS = 32;

    // one frame carries left then right
    parameter int FRAME_BITS = 2 * SAMPLE_BITS;

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // ====================
    // keys and sources
    // ====================

    parameter int NUM_KEYS = 4;  // push buttons on the board

    // playback source, matches the one bit switch at the top level
    typedef enum logic
    {
        SRC_FIFO  = 1'b0,  // playback fifo
        SRC_SYNTH = 1'b1   // synthesizer output
    } audio_src_e;

endpackage

`default_nettype wire

// ==== flist.f ====
audio_pkg.sv
i2s_bus_if.sv
i2s_clock_gen.sv
i2s_shift_out.sv
i2s_shift_in.sv
key_debounce.sv
audio_codec_top.sv
tb_clock.sv
audio_codec_chk.sv
audio_codec_tb.sv

// ==== i2s_bus_if.sv ====
// i2s timing bus from the clock generator to the serializer and deserializer
`timescale 1ns/1ps
`default_nettype none

interface i2s_bus_if;

    logic bclk;         // bit clock, as driven to the pin
    logic bclk_rise;    // one clk strobe with the rising bclk edge
    logic bclk_fall;    // one clk strobe with the falling bclk edge
    logic lrclk;        // word clock, low = left
    logic frame_start;  // falling edge strobe where lrclk drops

    modport gen
    (
        output bclk,
        output bclk_rise,
        output bclk_fall,
        output lrclk,
        output frame_start
    );

    modport shift
    (
        input bclk,
        input bclk_rise,
        input bclk_fall,
        input lrclk,
        input frame_start
    );

endinterface

`default_nettype wire

// ==== i2s_clock_gen.sv ====
// i2s clock generator, divides clk down to bit clock, word clock and frame strobes
`timescale 1ns/1ps
`default_nettype none

module i2s_clock_gen
#(
    parameter int BCLK_DIV = 8  // clk cycles per bclk half period
)
(
    input  logic      clk,
    input  logic      rst,
    i2s_bus_if.gen    bus
);

    localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int BIT_W = $clog2(audio_pkg::SAMPLE_BITS);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;  // bit slot inside the current channel
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_W'(BCLK_DIV - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt         <= '0;
            bit_cnt         <= BIT_W'(audio_pkg::SAMPLE_BITS - 1);  // first fall opens left
            bus.bclk        <= 1'b0;
            bus.lrclk       <= 1'b1;
            bus.bclk_rise   <= 1'b0;
            bus.bclk_fall   <= 1'b0;
            bus.frame_start <= 1'b0;
        end
        else
        begin
            bus.bclk_rise   <= 1'b0;
            bus.bclk_fall   <= 1'b0;
            bus.frame_start <= 1'b0;
            if (div_wrap)
            begin
                div_cnt  <= '0;
                bus.bclk <= ~bus.bclk;
                if (!bus.bclk)
                    bus.bclk_rise <= 1'b1;
                else
                begin
                    bus.bclk_fall <= 1'b1;
                    // word clock only moves on a falling edge
                    if (bit_cnt == BIT_W'(audio_pkg::SAMPLE_BITS - 1))
                    begin
                        bit_cnt         <= '0;
                        bus.lrclk       <= ~bus.lrclk;
                        bus.frame_start <= bus.lrclk;  // high to low starts a frame
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== i2s_shift_in.sv ====
// i2s capture deserializer, assembles a stereo pair and writes it when the fifo has room
`timescale 1ns/1ps
`default_nettype none

module i2s_shift_in
(
    input  logic               clk,
    input  logic               rst,
    i2s_bus_if.shift           bus,
    input  logic               enable,
    input  logic               fifo_ready,
    input  logic               data_in,
    output audio_pkg::sample_t fifo_left,
    output audio_pkg::sample_t fifo_right,
    output logic               fifo_write
);

    localparam int FRAME_BITS  = audio_pkg::FRAME_BITS;
    localparam int SAMPLE_BITS = audio_pkg::SAMPLE_BITS;
    localparam int CNT_W       = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0]      bit_cnt;     // rises since the last frame_start
    logic                  primed;      // a whole frame has been shifted in
    logic                  frame_done;

    // with the one bit delay the first rise of a frame is the old right lsb
    assign frame_done = bus.bclk_rise && primed && (bit_cnt == '0);

    // ====================
    // bit counting
    // ====================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bit_cnt    <= '0;
            primed     <= 1'b0;
            fifo_write <= 1'b0;
        end
        else
        begin
            if (bus.frame_start)
                bit_cnt <= '0;
            else if (bus.bclk_rise)
                bit_cnt <= bit_cnt + 1'b1;

            if (bus.bclk_rise && bit_cnt == CNT_W'(FRAME_BITS - 1))
                primed <= 1'b1;

            fifo_write <= frame_done && enable && fifo_ready;  // else the frame is dropped
        end
    end

    // ====================
    // data path
    // ====================
    always_ff @(posedge clk)
    begin
        if (bus.bclk_rise)
            shift_reg <= {shift_reg[FRAME_BITS-2:0], data_in};

        // pair held until the next accepted frame
        if (frame_done && enable && fifo_ready)
        begin
            fifo_left  <= shift_reg[FRAME_BITS-2 -: SAMPLE_BITS];
            fifo_right <= {shift_reg[SAMPLE_BITS-2:0], data_in};
        end
    end

endmodule

`default_nettype wire

// ==== i2s_shift_out.sv ====
// i2s playback serializer, loads one stereo pair per frame and shifts it out msb first
`timescale 1ns/1ps
`default_nettype none

module i2s_shift_out
(
    input  logic                  clk,
    input  logic                  rst,
    i2s_bus_if.shift              bus,
    input  logic                  enable,
    input  audio_pkg::audio_src_e src_sel,
    input  audio_pkg::sample_t    fifo_left,
    input  audio_pkg::sample_t    fifo_right,
    input  logic                  fifo_ready,
    output logic                  fifo_ack,
    input  audio_pkg::sample_t    synth_left,
    input  audio_pkg::sample_t    synth_right,
    output logic                  data_out
);

    localparam int FRAME_BITS = audio_pkg::FRAME_BITS;

    logic [FRAME_BITS-1:0] shift_reg;  // left in the upper half
    logic [FRAME_BITS-1:0] load_pair;
    logic                  fifo_take;

    // ====================
    // source select
    // ====================

    // fifo word is consumed only when it is really there
    assign fifo_take = enable && (src_sel == audio_pkg::SRC_FIFO) && fifo_ready;

    // ack lines up with the load edge
    assign fifo_ack = bus.frame_start && fifo_take;

    always_comb
    begin
        if (!enable)
            load_pair = '0;  // playback off, send silence
        else if (src_sel == audio_pkg::SRC_SYNTH)
            load_pair = {synth_left, synth_right};
        else if (fifo_ready)
            load_pair = {fifo_left, fifo_right};
        else
            load_pair = '0;  // underflow
    end

    // ====================
    // serial output
    // ====================

    // The frame_start fall still carries the previous right LSB, which gives
    // the one bit delay; the new left MSB goes out on the following fall.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            shift_reg <= '0;
            data_out  <= 1'b0;
        end
        else if (bus.bclk_fall)
        begin
            data_out <= shift_reg[FRAME_BITS-1];
            if (bus.frame_start)
                shift_reg <= load_pair;
            else
                shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};  // msb first
        end
    end

endmodule

`default_nettype wire

// ==== key_debounce.sv ====
// push-button debouncer, active low pins to active high stable key state
`timescale 1ns/1ps
`default_nettype none

module key_debounce
#(
    parameter int DEBOUNCE_TIMEOUT = 50000,  // clks of stable level
    parameter int TIMEOUT_WIDTH    = 16
)
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [audio_pkg::NUM_KEYS-1:0] key,
    output logic [audio_pkg::NUM_KEYS-1:0] key_state
);

    localparam int NUM_KEYS = audio_pkg::NUM_KEYS;

    logic [NUM_KEYS-1:0]      key_meta;
    logic [NUM_KEYS-1:0]      key_sync;
    logic [NUM_KEYS-1:0]      key_last;
    logic [TIMEOUT_WIDTH-1:0] stable_cnt [NUM_KEYS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_meta  <= '1;  // released
            key_sync  <= '1;
            key_last  <= '1;
            key_state <= '0;
            for (int i = 0; i < NUM_KEYS; i++)
                stable_cnt[i] <= '0;
        end
        else
        begin
            key_meta <= key;  // two stage synchronizer
            key_sync <= key_meta;
            for (int i = 0; i < NUM_KEYS; i++)
            begin
                if (key_sync[i] != key_last[i])
                begin
                    key_last[i]   <= key_sync[i];
                    stable_cnt[i] <= '0;  // bounce, start over
                end
                else if (stable_cnt[i] != TIMEOUT_WIDTH'(DEBOUNCE_TIMEOUT))
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                else
                    key_state[i] <= ~key_last[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the audio codec testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_codec_tb -f flist.f

./obj_dir/Vaudio_codec_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// ==== tb_clock.sv ====
// testbench clock source, free running clk with a fixed period
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter real PERIOD = 4.0  // ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
